//--- qna_macros.svh
/*
 * Register block constants
 * Bus widths, ack delay depth, word indices and reset values
 */
`ifndef QNA_MACROS_SVH
`define QNA_MACROS_SVH

// bus widths
`define QNA_DAT_W        16       // data bus width
`define QNA_ADR_W        3        // word address width
`define QNA_SEL_W        2        // byte selects

// ack delay line length
`define QNA_ACK_DEPTH    2

// descriptor list address fields
`define QNA_BDL_LO_W     15       // address bits 15:1, word aligned
`define QNA_BDL_HI_W     6        // address bits 21:16

// word indices in the register window
`define QNA_REG_LOCK     3'd0     // processor lock, proc side only
`define QNA_REG_RBDL_LO  3'd2
`define QNA_REG_RBDL_HI  3'd3
`define QNA_REG_TBDL_LO  3'd4
`define QNA_REG_TBDL_HI  3'd5
`define QNA_REG_VAR      3'd6
`define QNA_REG_CSR      3'd7

// reset values
`define QNA_CSR_RST      16'h0030 // rl and xl set, lists invalid
`define QNA_VEC_RST      8'h00    // interrupt vector

`endif

//--- qna_pkg.sv
/*
 * Register block types
 * Bus request, internal access, CSR/VAR layouts, descriptor address
 */
`default_nettype none
`include "qna_macros.svh"

package qna_pkg;

   typedef enum logic {
      SRC_HOST = 1'b0,                      // external host bus
      SRC_PROC = 1'b1                       // internal processor bus
   } src_t;

   typedef struct packed {
      logic                  cyc;           // bus cycle
      logic                  stb;           // strobe
      logic                  we;            // 1 write, 0 read
      logic [`QNA_SEL_W-1:0] sel;           // byte lanes
      logic [`QNA_ADR_W-1:0] adr;           // word index
      logic [`QNA_DAT_W-1:0] dat;           // write data
   } bus_req_t;

   typedef struct packed {
      logic                  valid;         // one cycle per granted access
      src_t                  src;           // which bus owns it
      logic                  we;
      logic [`QNA_SEL_W-1:0] sel;
      logic [`QNA_ADR_W-1:0] adr;
      logic [`QNA_DAT_W-1:0] dat;
   } access_t;

   typedef struct packed {
      logic ri;      // 15 rx interrupt, w1c from host
      logic rsv14;
      logic ca;      // 13 carrier, internal loopback only
      logic ok;      // 12 link ok
      logic rsv11;
      logic se;      // 10 sanity timer enable
      logic el;      // 9  external loopback
      logic il;      // 8  internal loopback, active low
      logic xi;      // 7  tx interrupt, w1c from host
      logic ie;      // 6  interrupt enable
      logic rl;      // 5  rx list invalid
      logic xl;      // 4  tx list invalid
      logic bd;      // 3  boot/diag rom
      logic ni;      // 2  nxm interrupt
      logic rsv1;    // soft reset position
      logic re;      // 0  receiver enable
   } csr_t;

   typedef struct packed {
      logic                  ms;            // mode select
      logic                  os;            // option switch
      logic                  rs;            // request self test
      logic                  s3;
      logic                  s2;
      logic                  s1;
      logic [7:0]            vec;           // interrupt vector 9:2
      logic                  rsv1;
      logic                  id;            // identity test bit
   } var_t;

   typedef struct packed {
      logic [`QNA_BDL_HI_W-1:0] hi;
      logic [`QNA_BDL_LO_W-1:0] lo;
   } bdl_t;

   typedef struct packed {
      logic re;
      logic il;
      logic el;
      logic se;
      logic bd;
   } eth_ctrl_t;

endpackage

`default_nettype wire

//--- qna_arbiter.sv
/*
 * Dual bus arbiter
 * Grants host or processor bus, host first, runs the ack delay
 * line and hands one access per grant to the register file
 */
`timescale 1ns/1ps
`default_nettype none
`include "qna_macros.svh"

module qna_arbiter (
   input  logic              lwb_clk_i,    // bus clock
   input  logic              comb_res,     // async reset
   input  qna_pkg::bus_req_t host_req_i,   // external host bus
   input  qna_pkg::bus_req_t proc_req_i,   // internal processor bus
   output logic              host_ack_o,
   output logic              proc_ack_o,
   output qna_pkg::access_t  access_o      // to register file
);
   import qna_pkg::*;

   localparam int D = `QNA_ACK_DEPTH;

   bus_req_t req [2];      // 0 host, 1 processor
   bus_req_t cur;          // request of the granted bus
   logic [1:0] seen;       // registered cyc & stb
   logic [1:0] gnt;        // grant flags
   logic [1:0] go;         // access cycle per bus
   logic [1:0] ack;

   assign req[0] = host_req_i;
   assign req[1] = proc_req_i;

   //*********************************************************************
   // grant, one bus at a time
   always_ff @(posedge lwb_clk_i or posedge comb_res) begin
      if (comb_res) begin
         seen <= '0;
         gnt  <= '0;
      end else begin
         for (int b = 0; b < 2; b++) begin
            seen[b] <= req[b].cyc & req[b].stb;
            if (gnt[b] && !req[b].cyc)
               gnt[b] <= 1'b0;                 // release after cyc falls
         end
         if (gnt == 2'b00) begin
            if (seen[0])
               gnt[0] <= 1'b1;                 // host wins a tie
            else if (seen[1])
               gnt[1] <= 1'b1;
         end
      end
   end

   //*********************************************************************
   // ack delay line per bus
   for (genvar b = 0; b < 2; b++) begin : g_bus
      logic [D-1:0] ack_q;                     // stage 0 first

      always_ff @(posedge lwb_clk_i or posedge comb_res) begin
         if (comb_res)
            ack_q <= '0;
         else if (gnt[b])
            ack_q <= {ack_q[D-2:0] & {(D-1){req[b].cyc}}, req[b].cyc & req[b].stb};
         else
            ack_q <= '0;                       // idle, no grant
      end

      // last but one stage set, last not yet set
      assign go[b]  = gnt[b] & req[b].cyc & req[b].stb & ack_q[D-2] & ~ack_q[D-1];
      assign ack[b] = req[b].cyc & req[b].stb & ack_q[D-1];
   end

   assign host_ack_o = ack[0];
   assign proc_ack_o = ack[1];

   //*********************************************************************
   // access to the register file
   assign cur = gnt[1] ? proc_req_i : host_req_i;

   always_comb begin
      access_o.valid = |go;
      access_o.src   = gnt[1] ? SRC_PROC : SRC_HOST;
      access_o.we    = cur.we;
      access_o.sel   = cur.sel;
      access_o.adr   = cur.adr;
      access_o.dat   = cur.dat;
   end

endmodule

`default_nettype wire

//--- qna_reg_file.sv
/*
 * Shared register file
 * CSR, VAR, rx/tx descriptor list addresses and processor lock,
 * byte lane writes from both buses, registered reads per bus
 */
`timescale 1ns/1ps
`default_nettype none
`include "qna_macros.svh"

module qna_reg_file (
   input  logic                  lwb_clk_i,
   input  logic                  comb_res,
   input  logic                  s3_i,        // mode switch s3
   input  logic                  s4_i,        // mode switch s4
   input  logic                  carrier_i,   // carrier from receiver
   input  logic                  link_i,      // link up from phy
   input  qna_pkg::access_t      access_i,
   output logic [`QNA_DAT_W-1:0] host_dat_o,
   output logic [`QNA_DAT_W-1:0] proc_dat_o,
   output logic                  irq_event_o,
   output logic                  ie_o,
   output qna_pkg::eth_ctrl_t    eth_ctrl_o,
   output qna_pkg::bdl_t         rbdl_o,
   output qna_pkg::bdl_t         tbdl_o
);
   import qna_pkg::*;

   localparam int DW = `QNA_DAT_W;

   csr_t  csr_q, csr_rd, wcsr;   // stored, read view, write data
   var_t  var_q, var_rst, wvar;
   bdl_t  rbdl_q, tbdl_q;
   logic  lock_q;                // processor holds the block
   logic  s3_n;
   logic  host_wr, proc_wr, host_rd, proc_rd;
   logic  host_ok;               // host writes allowed
   logic  ri_q, xi_q;            // previous ri, xi
   logic  evt_q;
   logic [DW-1:0] wdat, host_word, proc_word;

   assign wdat    = access_i.dat;
   assign wcsr    = csr_t'(wdat);
   assign wvar    = var_t'(wdat);
   assign host_wr = access_i.valid & access_i.we & (access_i.src == SRC_HOST);
   assign proc_wr = access_i.valid & access_i.we & (access_i.src == SRC_PROC);
   assign host_rd = access_i.valid & ~access_i.we & (access_i.src == SRC_HOST);
   assign proc_rd = access_i.valid & ~access_i.we & (access_i.src == SRC_PROC);
   assign host_ok = ~lock_q;

   // VAR after reset follows the switches
   assign s3_n    = ~s3_i;
   assign var_rst = '{ms: s3_n, os: s4_i & s3_n, rs: s3_n, s3: s3_n, s2: s3_n,
                      s1: s3_n, vec: `QNA_VEC_RST, rsv1: 1'b0, id: 1'b0};

   //*********************************************************************
   // register writes
   always_ff @(posedge lwb_clk_i or posedge comb_res) begin
      if (comb_res) begin
         csr_q  <= `QNA_CSR_RST;
         var_q  <= var_rst;
         rbdl_q <= '0;
         tbdl_q <= '0;
         lock_q <= 1'b0;
      end else if (host_wr) begin
         case (access_i.adr)
            `QNA_REG_RBDL_LO: if (host_ok) begin
               if (access_i.sel[0]) rbdl_q.lo[6:0]  <= wdat[7:1];
               if (access_i.sel[1]) rbdl_q.lo[14:7] <= wdat[15:8];
            end
            `QNA_REG_RBDL_HI: if (host_ok) begin
               if (access_i.sel[0]) rbdl_q.hi <= wdat[`QNA_BDL_HI_W-1:0];
               if (access_i.sel[1]) csr_q.rl  <= 1'b0;    // rx list now valid
            end
            `QNA_REG_TBDL_LO: if (host_ok) begin
               if (access_i.sel[0]) tbdl_q.lo[6:0]  <= wdat[7:1];
               if (access_i.sel[1]) tbdl_q.lo[14:7] <= wdat[15:8];
            end
            `QNA_REG_TBDL_HI: if (host_ok) begin
               if (access_i.sel[0]) tbdl_q.hi <= wdat[`QNA_BDL_HI_W-1:0];
               if (access_i.sel[1]) csr_q.xl  <= 1'b0;    // tx list now valid
            end
            `QNA_REG_VAR: begin                          // passes the lock
               if (access_i.sel[0]) begin
                  var_q.id       <= wvar.id;
                  var_q.vec[5:0] <= wvar.vec[5:0];
               end
               if (access_i.sel[1]) begin
                  var_q.vec[7:6] <= wvar.vec[7:6];
                  var_q.ms       <= wvar.ms;
                  if (!wvar.ms)
                     {var_q.os, var_q.rs, var_q.s3, var_q.s2, var_q.s1} <= '0;
                  else
                     var_q.rs <= wvar.rs;
               end
            end
            `QNA_REG_CSR: if (host_ok) begin
               if (access_i.sel[0]) begin
                  csr_q.ie <= wcsr.ie;
                  csr_q.re <= wcsr.re;
                  csr_q.bd <= wcsr.bd;
                  if (wcsr.xi) begin                     // w1c
                     csr_q.xi <= 1'b0;
                     csr_q.ni <= 1'b0;
                  end
               end
               if (access_i.sel[1]) begin
                  csr_q.il <= wcsr.il;
                  csr_q.el <= wcsr.el;
                  csr_q.se <= wcsr.se;
                  if (wcsr.ri)
                     csr_q.ri <= 1'b0;                   // w1c
               end
            end
            default: ;                                   // words 0, 1 unused
         endcase
      end else if (proc_wr) begin
         case (access_i.adr)
            `QNA_REG_LOCK:
               if (access_i.sel[0]) lock_q <= wdat[0];
            `QNA_REG_VAR:
               if (access_i.sel[1]) begin                // self test status
                  var_q.s1 <= wvar.s1;
                  var_q.s2 <= wvar.s2;
                  var_q.s3 <= wvar.s3;
                  var_q.rs <= wvar.rs;
               end
            `QNA_REG_CSR: begin
               if (access_i.sel[0]) begin
                  csr_q.ni <= wcsr.ni;
                  csr_q.xl <= wcsr.xl;
                  csr_q.rl <= wcsr.rl;
                  csr_q.xi <= wcsr.xi;                   // tx done event
               end
               if (access_i.sel[1])
                  csr_q.ri <= wcsr.ri;                   // rx done event
            end
            default: ;                                   // descriptors read only
         endcase
      end
   end

   //*********************************************************************
   // read side
   always_comb begin
      csr_rd    = csr_q;
      csr_rd.ca = csr_q.il & carrier_i;                  // carrier only with il
      csr_rd.ok = link_i;
   end

   always_comb begin
      case (access_i.adr)
         `QNA_REG_LOCK:    proc_word = {{(DW-1){1'b0}}, lock_q};
         `QNA_REG_RBDL_LO: proc_word = {rbdl_q.lo, 1'b0};
         `QNA_REG_RBDL_HI: proc_word = DW'(rbdl_q.hi);
         `QNA_REG_TBDL_LO: proc_word = {tbdl_q.lo, 1'b0};
         `QNA_REG_TBDL_HI: proc_word = DW'(tbdl_q.hi);
         `QNA_REG_VAR:     proc_word = var_q;
         `QNA_REG_CSR:     proc_word = csr_rd;
         default:          proc_word = '0;
      endcase
      // station address words dropped, host sees zero
      if (access_i.adr == `QNA_REG_VAR)
         host_word = var_q;
      else if (access_i.adr == `QNA_REG_CSR)
         host_word = csr_rd;
      else
         host_word = '0;
   end

   always_ff @(posedge lwb_clk_i) begin
      if (host_rd) host_dat_o <= host_word;
      if (proc_rd) proc_dat_o <= proc_word;
   end

   //*********************************************************************
   // new rx/tx event, one pulse per rising ri or xi
   always_ff @(posedge lwb_clk_i or posedge comb_res) begin
      if (comb_res) begin
         ri_q  <= 1'b0;
         xi_q  <= 1'b0;
         evt_q <= 1'b0;
      end else begin
         ri_q  <= csr_q.ri;
         xi_q  <= csr_q.xi;
         evt_q <= (csr_q.ri & ~ri_q) | (csr_q.xi & ~xi_q);
      end
   end

   assign irq_event_o = evt_q;
   assign ie_o        = csr_q.ie;
   assign eth_ctrl_o  = '{re: csr_q.re, il: csr_q.il, el: csr_q.el,
                          se: csr_q.se, bd: csr_q.bd};
   assign rbdl_o      = rbdl_q;
   assign tbdl_o      = tbdl_q;

endmodule

`default_nettype wire

//--- qna_irq_gen.sv
/*
 * Interrupt request
 * Latches an rx/tx event while enabled, holds it until iack
 */
`timescale 1ns/1ps
`default_nettype none

module qna_irq_gen (
   input  logic lwb_clk_i,
   input  logic comb_res,
   input  logic irq_event_i,   // one cycle event pulse
   input  logic ie_i,          // interrupt enable from CSR
   input  logic iack_i,        // bus interrupt acknowledge
   output logic irq_o
);

   logic req_q;                // pending request

   always_ff @(posedge lwb_clk_i or posedge comb_res) begin
      if (comb_res)
         req_q <= 1'b0;
      else if (irq_event_i && ie_i)
         req_q <= 1'b1;        // new event beats a same cycle iack
      else if (iack_i)
         req_q <= 1'b0;
   end

   assign irq_o = req_q;

endmodule

`default_nettype wire

//--- qna_regs_top.sv
/*
 * Dual bus register block of the Ethernet controller
 * Arbiter, shared register file and interrupt request
 */
`timescale 1ns/1ps
`default_nettype none
`include "qna_macros.svh"

module qna_regs_top (
   input  logic                  lwb_clk_i,   // common bus clock
   input  logic                  comb_res,    // async reset
   input  logic                  s3_i,        // mode switches
   input  logic                  s4_i,
   input  logic                  carrier_i,
   input  logic                  link_i,
   input  logic                  iack_i,
   input  qna_pkg::bus_req_t     host_req_i,  // external host bus
   input  qna_pkg::bus_req_t     proc_req_i,  // internal processor bus
   output logic [`QNA_DAT_W-1:0] host_dat_o,
   output logic [`QNA_DAT_W-1:0] proc_dat_o,
   output logic                  host_ack_o,
   output logic                  proc_ack_o,
   output logic                  irq_o,
   output qna_pkg::eth_ctrl_t    eth_ctrl_o,  // to ethernet core
   output qna_pkg::bdl_t         rbdl_o,
   output qna_pkg::bdl_t         tbdl_o
);
   import qna_pkg::*;

   access_t acc;          // arbiter to register file
   logic    irq_event;    // new rx/tx event
   logic    ie;           // CSR interrupt enable

   //*********************************************************************
   // stage 1, arbitration and ack
   qna_arbiter u_arb (
      .lwb_clk_i  (lwb_clk_i),
      .comb_res   (comb_res),
      .host_req_i (host_req_i),
      .proc_req_i (proc_req_i),
      .host_ack_o (host_ack_o),
      .proc_ack_o (proc_ack_o),
      .access_o   (acc)
   );

   //*********************************************************************
   // stage 2, register access
   qna_reg_file u_regs (
      .lwb_clk_i   (lwb_clk_i),
      .comb_res    (comb_res),
      .s3_i        (s3_i),
      .s4_i        (s4_i),
      .carrier_i   (carrier_i),
      .link_i      (link_i),
      .access_i    (acc),
      .host_dat_o  (host_dat_o),
      .proc_dat_o  (proc_dat_o),
      .irq_event_o (irq_event),
      .ie_o        (ie),
      .eth_ctrl_o  (eth_ctrl_o),
      .rbdl_o      (rbdl_o),
      .tbdl_o      (tbdl_o)
   );

   //*********************************************************************
   // stage 3, interrupt
   qna_irq_gen u_irq (
      .lwb_clk_i   (lwb_clk_i),
      .comb_res    (comb_res),
      .irq_event_i (irq_event),
      .ie_i        (ie),
      .iack_i      (iack_i),
      .irq_o       (irq_o)
   );

endmodule

`default_nettype wire

//--- tb_qna_regs.sv
/*
 * Testbench for the dual bus register block
 * Drives host and processor buses, keeps a register model and checks
 * acknowledge timing, arbitration, register sharing and interrupts
 */
`timescale 1ns/1ps
`default_nettype none
`include "qna_macros.svh"

module tb_qna_regs;
   import qna_pkg::*;

   localparam int N_DESC = 24;                       // random descriptor writes
   localparam int N_ACC  = 80;                       // accesses, rounded up
   localparam int LIMIT  = N_ACC * 10 + 300;         // cycles incl. reset

   logic lwb_clk_i, comb_res, s3_i, s4_i, carrier_i, link_i, iack_i;
   bus_req_t host_req, proc_req;
   logic [`QNA_DAT_W-1:0] host_dat, proc_dat;
   logic host_ack, proc_ack, irq;
   eth_ctrl_t eth_ctrl;
   bdl_t rbdl, tbdl;

   csr_t m_csr;                                      // register model
   var_t m_var;
   bdl_t m_rbdl, m_tbdl;
   logic m_lock;
   logic [31:0] lfsr = 32'hbe4b;
   int cycles = 0;
   int errors = 0, checks = 0, tests = 0, tests_bad = 0, err_mark;

   qna_regs_top uut (
      .lwb_clk_i(lwb_clk_i), .comb_res(comb_res), .s3_i(s3_i), .s4_i(s4_i),
      .carrier_i(carrier_i), .link_i(link_i), .iack_i(iack_i),
      .host_req_i(host_req), .proc_req_i(proc_req),
      .host_dat_o(host_dat), .proc_dat_o(proc_dat),
      .host_ack_o(host_ack), .proc_ack_o(proc_ack), .irq_o(irq),
      .eth_ctrl_o(eth_ctrl), .rbdl_o(rbdl), .tbdl_o(tbdl)
   );

   initial begin
      lwb_clk_i = 1'b0;
      forever #5 lwb_clk_i = ~lwb_clk_i;             // 10 ns period
   end

   always @(posedge lwb_clk_i) begin                 // run limit
      cycles <= cycles + 1;
      if (cycles >= LIMIT) begin
         $display("timeout: no end of run after %0d cycles", LIMIT);
         $display("Test failed");
         $finish;
      end
   end

   //*********************************************************************
   // helpers
   task automatic get_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);  // galois step
         v = {v[30:0], lfsr[0]};
      end
   endtask

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got === exp)
      else begin
         errors++;
         $display("error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic end_test(input string name);
      tests++;
      if (errors != err_mark) tests_bad++;
      $display("test %0d %s: %s", tests, name, (errors == err_mark) ? "ok" : "FAILED");
      err_mark = errors;
   endtask

   function automatic csr_t csr_view();                // ca and ok as read
      csr_t c;
      c = m_csr;
      c.ca = m_csr.il & carrier_i;
      c.ok = link_i;
      return c;
   endfunction

   function automatic logic [15:0] proc_expect(input logic [2:0] adr);
      case (adr)
         `QNA_REG_LOCK:    return {15'd0, m_lock};
         `QNA_REG_RBDL_LO: return {m_rbdl.lo, 1'b0};
         `QNA_REG_RBDL_HI: return {10'd0, m_rbdl.hi};
         `QNA_REG_TBDL_LO: return {m_tbdl.lo, 1'b0};
         `QNA_REG_TBDL_HI: return {10'd0, m_tbdl.hi};
         `QNA_REG_VAR:     return m_var;
         `QNA_REG_CSR:     return csr_view();
         default:          return 16'd0;
      endcase
   endfunction

   //*********************************************************************
   // one bus access per the bus rule, latency counted from edge 0
   task automatic bus_cycle(input logic is_proc, input logic we, input logic [1:0] sel,
                            input logic [2:0] adr, input logic [15:0] dat,
                            output logic [15:0] rdat, output int lat);
      bus_req_t r;
      int n;
      logic ack;
      r.cyc = 1'b1;
      r.stb = 1'b1;
      r.we  = we;
      r.sel = sel;
      r.adr = adr;
      r.dat = dat;
      n = 0;
      @(posedge lwb_clk_i);
      if (is_proc) proc_req <= r;
      else host_req <= r;
      do begin
         @(negedge lwb_clk_i);
         n++;
         ack = is_proc ? proc_ack : host_ack;
      end while (!ack);
      rdat = is_proc ? proc_dat : host_dat;
      lat  = n - 2;                                  // first negedge is before edge 0
      @(posedge lwb_clk_i);
      if (is_proc) proc_req <= '0;
      else host_req <= '0;
      @(negedge lwb_clk_i);
   endtask

   task automatic host_write(input logic [2:0] adr, input logic [1:0] sel,
                             input logic [15:0] d);
      logic [15:0] r, w;
      int lat;
      bus_cycle(1'b0, 1'b1, sel, adr, d, r, lat);
      check("host_ack latency", lat, 3);
      if (adr == `QNA_REG_VAR) begin                 // not blocked by the lock
         if (sel[0]) begin
            m_var.id = d[0];
            m_var.vec[5:0] = d[7:2];
         end
         if (sel[1]) begin
            m_var.vec[7:6] = d[9:8];
            m_var.ms = d[15];
            if (!d[15]) {m_var.os, m_var.rs, m_var.s3, m_var.s2, m_var.s1} = '0;
            else m_var.rs = d[13];
         end
      end else if (!m_lock) begin
         case (adr)
            `QNA_REG_RBDL_LO, `QNA_REG_TBDL_LO: begin
               w = (adr == `QNA_REG_RBDL_LO) ? {m_rbdl.lo, 1'b0} : {m_tbdl.lo, 1'b0};
               if (sel[0]) w[7:0] = d[7:0];
               if (sel[1]) w[15:8] = d[15:8];
               if (adr == `QNA_REG_RBDL_LO) m_rbdl.lo = w[15:1];
               else m_tbdl.lo = w[15:1];
            end
            `QNA_REG_RBDL_HI: begin
               if (sel[0]) m_rbdl.hi = d[5:0];
               if (sel[1]) m_csr.rl = 1'b0;
            end
            `QNA_REG_TBDL_HI: begin
               if (sel[0]) m_tbdl.hi = d[5:0];
               if (sel[1]) m_csr.xl = 1'b0;
            end
            `QNA_REG_CSR: begin
               if (sel[0]) begin
                  m_csr.re = d[0];
                  m_csr.bd = d[3];
                  m_csr.ie = d[6];
                  if (d[7]) {m_csr.xi, m_csr.ni} = 2'b00;
               end
               if (sel[1]) begin
                  m_csr.il = d[8];
                  m_csr.el = d[9];
                  m_csr.se = d[10];
                  if (d[15]) m_csr.ri = 1'b0;
               end
            end
            default: ;
         endcase
      end
      check("eth_ctrl_o", eth_ctrl,
            {m_csr.re, m_csr.il, m_csr.el, m_csr.se, m_csr.bd});
   endtask

   task automatic proc_write(input logic [2:0] adr, input logic [1:0] sel,
                             input logic [15:0] d);
      logic [15:0] r;
      int lat;
      bus_cycle(1'b1, 1'b1, sel, adr, d, r, lat);
      check("proc_ack latency", lat, 3);
      if (adr == `QNA_REG_LOCK && sel[0]) m_lock = d[0];
      if (adr == `QNA_REG_VAR && sel[1]) begin        // self test bits
         m_var.s1 = d[10];
         m_var.s2 = d[11];
         m_var.s3 = d[12];
         m_var.rs = d[13];
      end
      if (adr == `QNA_REG_CSR) begin
         if (sel[0]) begin
            m_csr.ni = d[2];
            m_csr.xl = d[4];
            m_csr.rl = d[5];
            m_csr.xi = d[7];
         end
         if (sel[1]) m_csr.ri = d[15];
      end
   endtask

   task automatic proc_read(input logic [2:0] adr);
      logic [15:0] r;
      int lat;
      bus_cycle(1'b1, 1'b0, 2'b11, adr, 16'd0, r, lat);
      check("proc_ack latency", lat, 3);
      check($sformatf("proc_dat_o word %0d", adr), r, proc_expect(adr));
   endtask

   task automatic host_read(input logic [2:0] adr);
      logic [15:0] r;
      int lat;
      bus_cycle(1'b0, 1'b0, 2'b11, adr, 16'd0, r, lat);
      check("host_ack latency", lat, 3);
      check($sformatf("host_dat_o word %0d", adr), r,
            (adr >= `QNA_REG_VAR) ? proc_expect(adr) : 16'd0);
   endtask

   //*********************************************************************
   // test sequence
   initial begin
      logic [31:0] v, d;
      logic [15:0] rh, rp;
      int lh, lp, k;
      host_req  = '0;
      proc_req  = '0;
      iack_i    = 1'b0;
      carrier_i = 1'b0;
      get_bits(3, v);
      s3_i   = v[0];                                  // random mode switches
      s4_i   = v[1];
      link_i = v[2];
      comb_res = 1'b1;
      err_mark = 0;
      repeat (10) @(posedge lwb_clk_i);
      comb_res <= 1'b0;
      m_csr = '0;
      m_csr.rl = 1'b1;
      m_csr.xl = 1'b1;
      m_var = '{ms: ~s3_i, os: s4_i & ~s3_i, rs: ~s3_i, s3: ~s3_i, s2: ~s3_i,
                s1: ~s3_i, vec: 8'h00, rsv1: 1'b0, id: 1'b0};
      m_rbdl = '0;
      m_tbdl = '0;
      m_lock = 1'b0;

      // 1 reset values
      @(negedge lwb_clk_i);
      check("irq_o", irq, 0);
      check("host_ack_o", host_ack, 0);
      check("proc_ack_o", proc_ack, 0);
      proc_read(`QNA_REG_VAR);
      proc_read(`QNA_REG_CSR);
      end_test("reset values");

      // 2 ack timing and arbitration
      host_read(`QNA_REG_CSR);
      fork
         bus_cycle(1'b0, 1'b0, 2'b11, `QNA_REG_VAR, 16'd0, rh, lh);
         bus_cycle(1'b1, 1'b0, 2'b11, `QNA_REG_VAR, 16'd0, rp, lp);
      join
      check("host_ack latency, tie", lh, 3);
      check("proc_ack latency, tie", lp, lh + 5);     // after host release
      check("host_dat_o", rh, m_var);
      check("proc_dat_o", rp, m_var);
      end_test("ack timing and arbitration");

      // 3 descriptor addresses
      for (int i = 0; i < N_DESC; i++) begin
         get_bits(2, v);
         repeat (v) @(negedge lwb_clk_i);            // random start gap
         get_bits(2, v);
         get_bits(2, d);
         get_bits(16, k);
         host_write(3'd2 + v[1:0], (d[1:0] == 2'b00) ? 2'b11 : d[1:0], k[15:0]);
         check("rbdl_o", rbdl, m_rbdl);
         check("tbdl_o", tbdl, m_tbdl);
      end
      for (int a = 2; a <= 5; a++) proc_read(a[2:0]);
      for (int a = 0; a <= 5; a++) host_read(a[2:0]);
      host_write(`QNA_REG_RBDL_HI, 2'b10, 16'h0000);
      host_write(`QNA_REG_TBDL_HI, 2'b10, 16'h0000);
      proc_read(`QNA_REG_CSR);
      end_test("descriptor addresses");

      // 4 lock bit
      proc_write(`QNA_REG_LOCK, 2'b01, 16'h0001);
      proc_read(`QNA_REG_LOCK);
      get_bits(16, d);
      host_write(`QNA_REG_RBDL_LO, 2'b11, d[15:0]);
      host_write(`QNA_REG_TBDL_HI, 2'b11, ~d[15:0]);
      host_write(`QNA_REG_CSR, 2'b11, 16'h0749);
      check("rbdl_o, locked", rbdl, m_rbdl);
      check("tbdl_o, locked", tbdl, m_tbdl);
      host_write(`QNA_REG_VAR, 2'b11, {1'b1, 1'b0, d[13], 3'b000, d[9:0]});
      proc_read(`QNA_REG_VAR);
      proc_read(`QNA_REG_CSR);
      proc_write(`QNA_REG_LOCK, 2'b01, 16'h0000);
      end_test("lock bit");

      // 5 CSR sharing
      proc_write(`QNA_REG_CSR, 2'b11, 16'h8080);      // set ri and xi
      proc_read(`QNA_REG_CSR);
      host_write(`QNA_REG_CSR, 2'b11, 16'h8080);      // w1c both
      proc_read(`QNA_REG_CSR);
      @(posedge lwb_clk_i);
      carrier_i <= 1'b1;
      link_i    <= ~link_i;
      host_write(`QNA_REG_CSR, 2'b11, 16'h0709);      // il, el, se, re and bd on
      proc_read(`QNA_REG_CSR);
      host_read(`QNA_REG_CSR);
      @(posedge lwb_clk_i);
      carrier_i <= 1'b0;                              // ca follows carrier with il on
      proc_read(`QNA_REG_CSR);
      @(posedge lwb_clk_i);
      carrier_i <= 1'b1;
      host_write(`QNA_REG_CSR, 2'b10, 16'h0000);      // il off
      proc_read(`QNA_REG_CSR);
      end_test("CSR sharing");

      // 6 interrupt
      host_write(`QNA_REG_CSR, 2'b01, 16'h0040);      // ie on
      proc_write(`QNA_REG_CSR, 2'b01, 16'h0080);      // tx event
      k = 0;
      while (!irq && k < 10) begin
         @(negedge lwb_clk_i);
         k++;
      end
      assert (irq)
      else begin
         errors++;
         $display("irq_o never rose after a tx event with ie set");
      end
      repeat (4) @(negedge lwb_clk_i);
      check("irq_o, held", irq, 1);
      @(posedge lwb_clk_i);
      iack_i <= 1'b1;
      @(posedge lwb_clk_i);
      iack_i <= 1'b0;
      @(negedge lwb_clk_i);
      check("irq_o, after iack", irq, 0);
      host_write(`QNA_REG_CSR, 2'b01, 16'h0080);      // ie off, clear xi
      proc_write(`QNA_REG_CSR, 2'b01, 16'h0080);
      repeat (8) @(negedge lwb_clk_i);
      check("irq_o, ie clear", irq, 0);
      proc_read(`QNA_REG_CSR);
      end_test("interrupt");

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests, tests_bad, checks, errors);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- project.f
+incdir+.
qna_pkg.sv
qna_arbiter.sv
qna_reg_file.sv
qna_irq_gen.sv
qna_regs_top.sv
tb_qna_regs.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_qna_regs
FLIST     ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

$(OBJ_DIR)/V$(TOP): $(shell grep -v '^+' $(FLIST)) qna_macros.svh
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "Test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
